// ==== verilog/csr_defs.svh ====
// CSR block widths, counts, address offsets and read-only bit masks

`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// --------------------------------------------------
// Widths and counts
// --------------------------------------------------
`define XLEN              32
`define CSR_ADDR_W        12
`define CAUSE_W           4
`define NUM_HPM           4
`define EVENT_SEL_W       4
`define NUM_EVENTS        16

// Upper counter halves sit 0x80 above the lower halves
`define CNT_HI_OFS        12'h080
// First hpm counter number, also its mcountinhibit bit
`define HPM_FIRST         3
// Event vector bit that carries the plain retire flag
`define EV_RETIRE         14

// --------------------------------------------------
// Read-only masks, a set bit keeps its current value
// --------------------------------------------------
// mstatus writable: MIE(3), MPIE(7), MPP(12:11)
`define MSTATUS_RO_MASK   32'hFFFF_E777
// mie writable: MSIE(3), MTIE(7), MEIE(11)
`define MIE_RO_MASK       32'hFFFF_F777
// mip writable: MSIP(3) only
`define MIP_RO_MASK       32'hFFFF_FFF7
// Only direct and vectored modes, so MODE bit 1 stays 0
`define MTVEC_RO_MASK     32'h0000_0002
// No compressed ISA, so the pc is always 2-byte aligned at least
`define MEPC_RO_MASK      32'h0000_0001
// CY(0), IR(2) and HPM3..HPM6(6:3) writable, TM(1) hardwired low
`define MINHIBIT_RO_MASK  32'hFFFF_FF82

// MXL=1 (32 bit), extensions I and M
`define MISA_VALUE        32'h4000_1100
`define MTVEC_INIT        32'h0000_0100

`endif

// ==== verilog/csr_map_pkg.sv ====
// Machine mode CSR address type and the map of every implemented CSR

`include "csr_defs.svh"

package csr_map_pkg;

   typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

   // --------------------------------------------------
   // Implemented CSR addresses, standard encodings
   // --------------------------------------------------
   typedef enum csr_addr_t {
      // Trap setup
      csr_mstatus       = 12'h300,
      csr_misa          = 12'h301,
      csr_mie           = 12'h304,
      csr_mtvec         = 12'h305,
      csr_mcountinhibit = 12'h320,
      // Event selectors, mhpmevent4..6 follow in order
      csr_mhpmevent3    = 12'h323,
      // Trap handling
      csr_mscratch      = 12'h340,
      csr_mepc          = 12'h341,
      csr_mcause        = 12'h342,
      csr_mtval         = 12'h343,
      csr_mip           = 12'h344,
      // Counter lower halves, hpm counters 4..6 follow in order
      csr_mcycle        = 12'hB00,
      csr_minstret      = 12'hB02,
      csr_mhpmcounter3  = 12'hB03,
      // Counter upper halves
      csr_mcycleh       = 12'hB80,
      csr_minstreth     = 12'hB82,
      csr_mhpmcounter3h = 12'hB83
   } csr_addr_e;

endpackage

// ==== verilog/csr_types_pkg.sv ====
// Data types, instruction classes and access/event structs of the CSR block

`include "csr_defs.svh"

package csr_types_pkg;
   import csr_map_pkg::*;

   typedef logic [`XLEN-1:0]        xlen_t;
   typedef logic [2*`XLEN-1:0]      counter_t;
   typedef logic [`EVENT_SEL_W-1:0] event_sel_t;
   typedef logic [`NUM_EVENTS-1:0]  event_vec_t;
   typedef logic [`CAUSE_W-1:0]     exc_cause_t;

   // Encodings 1..10 line up with event vector bits 1..10
   typedef enum logic [3:0] {
      class_none, class_load, class_store, class_csr, class_system,
      class_alu, class_branch, class_jal, class_jalr, class_mul, class_div
   } instr_class_e;

   // --------------------------------------------------
   // Access port
   // --------------------------------------------------
   typedef struct packed {
      logic      we;
      csr_addr_t addr;
      xlen_t     wdata;
   } csr_req_t;

   typedef struct packed {
      xlen_t rdata;
      logic  illegal;
   } csr_rsp_t;

   // What the pipeline retired or trapped on in one cycle
   typedef struct packed {
      logic         retire;
      instr_class_e iclass;
      logic         exc;
      exc_cause_t   cause;
      logic         ext_irq;
   } retire_events_t;

endpackage

// ==== verilog/csr_trap_regs.sv ====
// Machine trap setup and trap handling registers with masked writes and local read decode

`timescale 1ns/100ps

`include "csr_defs.svh"

module csr_trap_regs
   import csr_map_pkg::*, csr_types_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     req_valid,
   input  csr_req_t req,
   output xlen_t    rdata,
   output logic     hit,
   output xlen_t    minhibit
);

   xlen_t mstatus;
   xlen_t mie;
   xlen_t mtvec;
   xlen_t mscratch;
   xlen_t mepc;
   xlen_t mcause;
   xlen_t mtval;
   xlen_t mip;
   logic  wr;

   // Read-only bits come from the old value, the rest from the write data
   function automatic xlen_t masked_write(input xlen_t old_val, input xlen_t new_val,
                                          input xlen_t ro_mask);
      masked_write = (old_val & ro_mask) | (new_val & ~ro_mask);
   endfunction

   assign wr = req_valid & req.we;

   // --------------------------------------------------
   // Register update
   // --------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         mstatus  <= '0;
         mie      <= '0;
         // Bit 1 of the init value is already 0
         mtvec    <= `MTVEC_INIT;
         mscratch <= '0;
         mepc     <= '0;
         mcause   <= '0;
         mtval    <= '0;
         mip      <= '0;
         minhibit <= '0;
      end
      else if (wr)
      begin
         // misa is a constant and has no entry here
         case (req.addr)
            csr_mstatus:       mstatus  <= masked_write(mstatus, req.wdata, `MSTATUS_RO_MASK);
            csr_mie:           mie      <= masked_write(mie, req.wdata, `MIE_RO_MASK);
            csr_mtvec:         mtvec    <= masked_write(mtvec, req.wdata, `MTVEC_RO_MASK);
            csr_mscratch:      mscratch <= req.wdata;
            csr_mepc:          mepc     <= masked_write(mepc, req.wdata, `MEPC_RO_MASK);
            csr_mcause:        mcause   <= req.wdata;
            csr_mtval:         mtval    <= req.wdata;
            csr_mip:           mip      <= masked_write(mip, req.wdata, `MIP_RO_MASK);
            csr_mcountinhibit: minhibit <= masked_write(minhibit, req.wdata, `MINHIBIT_RO_MASK);
            default:           ;
         endcase
      end
   end

   // --------------------------------------------------
   // Read decode, old value of the request cycle
   // --------------------------------------------------
   always_comb
   begin
      hit   = 1'b1;
      rdata = '0;
      case (req.addr)
         csr_mstatus:       rdata = mstatus;
         csr_misa:          rdata = `MISA_VALUE;
         csr_mie:           rdata = mie;
         csr_mtvec:         rdata = mtvec;
         csr_mscratch:      rdata = mscratch;
         csr_mepc:          rdata = mepc;
         csr_mcause:        rdata = mcause;
         csr_mtval:         rdata = mtval;
         csr_mip:           rdata = mip;
         csr_mcountinhibit: rdata = minhibit;
         // Not in this bank
         default:           hit = 1'b0;
      endcase
   end

endmodule

// ==== verilog/csr_event_decode.sv ====
// Per-cycle decode of retirement and exception events into the performance event vector

`timescale 1ns/100ps

`include "csr_defs.svh"

module csr_event_decode
   import csr_types_pkg::*;
(
   input  retire_events_t events,
   output event_vec_t     event_vec
);

   // Causes 0, 4 and 6 are the misaligned instruction, load and store traps
   logic misaligned;
   logic any_jump;

   assign misaligned = events.exc &&
                       (events.cause == 4'd0 || events.cause == 4'd4 || events.cause == 4'd6);
   assign any_jump   = events.retire &&
                       (events.iclass == class_branch || events.iclass == class_jal ||
                        events.iclass == class_jalr);

   always_comb
   begin
      // Selector 0 never counts
      event_vec[0] = 1'b0;
      // One bit per retired class, bit number equals the class encoding
      for (int i = int'(class_load); i <= int'(class_div); i++)
      begin
         event_vec[i] = events.retire && (events.iclass == instr_class_e'(i));
      end
      event_vec[11]         = any_jump;
      event_vec[12]         = misaligned;
      // Illegal instruction
      event_vec[13]         = events.exc && (events.cause == 4'd2);
      event_vec[`EV_RETIRE] = events.retire;
      event_vec[15]         = events.ext_irq;
   end

endmodule

// ==== verilog/csr_counters.sv ====
// 64-bit cycle, instret and hpm counters with their event selectors and read decode

`timescale 1ns/100ps

`include "csr_defs.svh"

module csr_counters
   import csr_map_pkg::*, csr_types_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       req_valid,
   input  csr_req_t   req,
   input  event_vec_t event_vec,
   input  xlen_t      minhibit,
   output xlen_t      rdata,
   output logic       hit
);

   // Index 0 is mcycle, 1 is minstret, 2 and up are the hpm counters
   localparam int NUM_CNT = 2 + `NUM_HPM;

   counter_t           cnt [NUM_CNT];
   event_sel_t         mhpmevent [`NUM_HPM];
   logic [NUM_CNT-1:0] inc;
   logic [NUM_CNT-1:0] wr_lo;
   logic [NUM_CNT-1:0] wr_hi;
   logic [`NUM_HPM-1:0] wr_ev;
   logic               wr;

   // Lower half address of counter idx, minstret and hpm counters are contiguous
   function automatic csr_addr_t lo_addr(input int unsigned idx);
      if (idx == 0)
         lo_addr = csr_mcycle;
      else
         lo_addr = csr_addr_t'(csr_minstret) + csr_addr_t'(idx - 1);
   endfunction

   function automatic csr_addr_t ev_addr(input int unsigned idx);
      ev_addr = csr_addr_t'(csr_mhpmevent3) + csr_addr_t'(idx);
   endfunction

   assign wr = req_valid & req.we;

   // --------------------------------------------------
   // Write decode and increment enables
   // --------------------------------------------------
   always_comb
   begin
      for (int i = 0; i < NUM_CNT; i++)
      begin
         wr_lo[i] = wr && (req.addr == lo_addr(i));
         wr_hi[i] = wr && (req.addr == lo_addr(i) + `CNT_HI_OFS);
      end
      inc[0] = ~minhibit[0];
      inc[1] = event_vec[`EV_RETIRE] & ~minhibit[2];
      for (int k = 0; k < `NUM_HPM; k++)
      begin
         wr_ev[k]  = wr && (req.addr == ev_addr(k));
         inc[2+k]  = event_vec[mhpmevent[k]] & ~minhibit[`HPM_FIRST+k];
      end
   end

   // Software write to either half wins over the count of that cycle
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < NUM_CNT; i++)
            cnt[i] <= '0;
         for (int k = 0; k < `NUM_HPM; k++)
            mhpmevent[k] <= '0;
      end
      else
      begin
         for (int i = 0; i < NUM_CNT; i++)
         begin
            if (wr_lo[i])
               cnt[i][`XLEN-1:0] <= req.wdata;
            else if (wr_hi[i])
               cnt[i][2*`XLEN-1:`XLEN] <= req.wdata;
            else if (inc[i])
               cnt[i] <= cnt[i] + counter_t'(1);
         end
         for (int k = 0; k < `NUM_HPM; k++)
         begin
            if (wr_ev[k])
               mhpmevent[k] <= req.wdata[`EVENT_SEL_W-1:0];
         end
      end
   end

   // --------------------------------------------------
   // Read decode
   // --------------------------------------------------
   always_comb
   begin
      hit   = 1'b0;
      rdata = '0;
      for (int i = 0; i < NUM_CNT; i++)
      begin
         if (req.addr == lo_addr(i))
         begin
            hit   = 1'b1;
            rdata = cnt[i][`XLEN-1:0];
         end
         if (req.addr == lo_addr(i) + `CNT_HI_OFS)
         begin
            hit   = 1'b1;
            rdata = cnt[i][2*`XLEN-1:`XLEN];
         end
      end
      for (int k = 0; k < `NUM_HPM; k++)
      begin
         if (req.addr == ev_addr(k))
         begin
            hit   = 1'b1;
            rdata = {{(`XLEN-`EVENT_SEL_W){1'b0}}, mhpmevent[k]};
         end
      end
   end

endmodule

// ==== verilog/csr_access.sv ====
// Response stage that merges bank read data and flags unclaimed CSR addresses

`timescale 1ns/100ps

module csr_access
   import csr_types_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     req_valid,
   input  logic     trap_hit,
   input  logic     cnt_hit,
   input  xlen_t    trap_rdata,
   input  xlen_t    cnt_rdata,
   output logic     rsp_valid,
   output csr_rsp_t rsp
);

   csr_rsp_t rsp_next;

   // Banks never claim the same address, trap bank takes priority anyway
   always_comb
   begin
      rsp_next.illegal = ~(trap_hit | cnt_hit);
      if (trap_hit)
         rsp_next.rdata = trap_rdata;
      else if (cnt_hit)
         rsp_next.rdata = cnt_rdata;
      else
         rsp_next.rdata = '0;
   end

   // --------------------------------------------------
   // One cycle response, valid qualifies the payload
   // --------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         rsp_valid <= 1'b0;
      else
         rsp_valid <= req_valid;
   end

   always_ff @(posedge clk)
   begin
      if (req_valid)
         rsp <= rsp_next;
   end

endmodule

// ==== verilog/csr_top.sv ====
// Machine mode CSR block top level with one access port and retirement event input

`timescale 1ns/100ps

module csr_top
   import csr_types_pkg::*;
(
   input  logic           clk,
   input  logic           rst_n,
   input  logic           req_valid,
   input  csr_req_t       req,
   input  retire_events_t events,
   output logic           rsp_valid,
   output csr_rsp_t       rsp
);

   xlen_t      trap_rdata;
   xlen_t      cnt_rdata;
   logic       trap_hit;
   logic       cnt_hit;
   // mcountinhibit lives in the trap bank and gates the counters
   xlen_t      minhibit;
   event_vec_t event_vec;

   csr_trap_regs u_trap_regs (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req       (req),
      .rdata     (trap_rdata),
      .hit       (trap_hit),
      .minhibit  (minhibit)
   );

   csr_event_decode u_event_decode (
      .events    (events),
      .event_vec (event_vec)
   );

   csr_counters u_counters (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req       (req),
      .event_vec (event_vec),
      .minhibit  (minhibit),
      .rdata     (cnt_rdata),
      .hit       (cnt_hit)
   );

   csr_access u_access (
      .clk        (clk),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .trap_hit   (trap_hit),
      .cnt_hit    (cnt_hit),
      .trap_rdata (trap_rdata),
      .cnt_rdata  (cnt_rdata),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp)
   );

endmodule

// ==== tb/csr_assert.sv ====
// Bound checks on the CSR block response timing and hardwired trap bits

`timescale 1ns/100ps

module csr_assert
   import csr_types_pkg::*;
(
   input logic  clk,
   input logic  rst_n,
   input logic  req_valid,
   input logic  rsp_valid,
   input xlen_t mtvec,
   input xlen_t mepc
);

   // Number of failed assertions so far
   int unsigned fail_count = 0;

   // Response one cycle after each request
   rsp_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
                                     rsp_valid == $past(req_valid))
      else
      begin
         $error("rsp_valid does not follow req_valid by one cycle");
         fail_count = fail_count + 1;
      end

   // Sampled mid cycle after the first reset edge
   rsp_low_in_reset: assert property (@(negedge clk) !rst_n |-> !rsp_valid)
      else
      begin
         $error("rsp_valid high while in reset");
         fail_count = fail_count + 1;
      end

   mtvec_mode_bit: assert property (@(posedge clk) disable iff (!rst_n) mtvec[1] == 1'b0)
      else
      begin
         $error("mtvec bit 1 is set");
         fail_count = fail_count + 1;
      end

   mepc_align_bit: assert property (@(posedge clk) disable iff (!rst_n) mepc[0] == 1'b0)
      else
      begin
         $error("mepc bit 0 is set");
         fail_count = fail_count + 1;
      end

endmodule

bind csr_top csr_assert u_assert (
   .clk       (clk),
   .rst_n     (rst_n),
   .req_valid (req_valid),
   .rsp_valid (rsp_valid),
   .mtvec     (u_trap_regs.mtvec),
   .mepc      (u_trap_regs.mepc)
);

// ==== tb/csr_tb.sv ====
// Testbench for the CSR block, random requests and events checked against a reference model

`timescale 1ns/100ps

`include "csr_defs.svh"

module csr_tb
   import csr_map_pkg::*, csr_types_pkg::*;
();

   // --------------------------------------------------
   // Phase lengths and run limit
   // --------------------------------------------------
   localparam int n_trap    = 200;
   localparam int n_unimpl  = 60;
   localparam int n_carry   = 8;
   localparam int n_base    = 200;
   localparam int n_hpm     = 300;
   localparam int n_inhibit = 120;
   localparam int n_freeze  = 20;
   localparam int test_cycles = 8 + 3 * 10 + n_trap + n_unimpl + 3 + n_carry + n_base + n_hpm +
                                n_inhibit + 2 * (n_freeze + 1) + 1;
   localparam int timeout_cycles = 2 * test_cycles;

   // Writable bits per CSR where a clear bit keeps its old value
   localparam xlen_t wmask_mstatus  = 32'h0000_1888;
   localparam xlen_t wmask_mie      = 32'h0000_0888;
   localparam xlen_t wmask_mip      = 32'h0000_0008;
   localparam xlen_t wmask_mtvec    = 32'hFFFF_FFFD;
   localparam xlen_t wmask_mepc     = 32'hFFFF_FFFE;
   localparam xlen_t wmask_minhibit = 32'h0000_007D;

   // Address pools with the counter lower halves in the order mcycle, minstret, hpm3..hpm6
   localparam csr_addr_t trap_pool [10] = '{csr_mstatus, csr_misa, csr_mie, csr_mtvec,
      csr_mcountinhibit, csr_mscratch, csr_mepc, csr_mcause, csr_mtval, csr_mip};
   localparam csr_addr_t cnt_lo_addr [6] = '{12'hB00, 12'hB02, 12'hB03, 12'hB04, 12'hB05,
      12'hB06};
   localparam csr_addr_t sel_addr [4] = '{12'h323, 12'h324, 12'h325, 12'h326};
   localparam csr_addr_t base_pool [4] = '{12'hB00, 12'hB80, 12'hB02, 12'hB82};
   localparam csr_addr_t hpm_pool [12] = '{12'hB03, 12'hB04, 12'hB05, 12'hB06, 12'hB83,
      12'hB84, 12'hB85, 12'hB86, 12'h323, 12'h324, 12'h325, 12'h326};

   logic           clk       = 1'b0;
   logic           rst_n     = 1'b0;
   logic           req_valid = 1'b0;
   csr_req_t       req       = '0;
   retire_events_t events    = '0;
   logic           rsp_valid;
   csr_rsp_t       rsp;

   // Values for the next rising edge
   logic           nxt_rst_n  = 1'b0;
   logic           nxt_valid  = 1'b0;
   csr_req_t       nxt_req    = '0;
   retire_events_t nxt_events = '0;

   integer seed = 32'hf91546f2;
   int     cycle_count = 0;

   // Expected response of the request now in flight
   logic  exp_valid = 1'b0;
   xlen_t exp_rdata = '0;
   logic  exp_illegal = 1'b0;

   // Reference model state
   xlen_t      m_mstatus;
   xlen_t      m_mie;
   xlen_t      m_mtvec;
   xlen_t      m_mscratch;
   xlen_t      m_mepc;
   xlen_t      m_mcause;
   xlen_t      m_mtval;
   xlen_t      m_mip;
   xlen_t      m_minhibit;
   counter_t   m_cnt [6];
   event_sel_t m_sel [4];

   csr_top DUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req       (req),
      .events    (events),
      .rsp_valid (rsp_valid),
      .rsp       (rsp)
   );

   always #10 clk = ~clk;

   always @(posedge clk)
   begin
      rst_n     <= nxt_rst_n;
      req_valid <= nxt_valid;
      req       <= nxt_req;
      events    <= nxt_events;
   end

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count >= timeout_cycles)
         fail_run($sformatf("Timeout after %0d cycles, the tests did not finish", cycle_count));
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "Run stopped");
   endtask

   task automatic value_error(input string name, input xlen_t exp, input xlen_t got);
      fail_run($sformatf("[FAIL] t=%0t %s expected 0x%08h got 0x%08h", $time, name, exp, got));
   endtask

   // --------------------------------------------------
   // Reference model
   // --------------------------------------------------
   function automatic xlen_t keep_ro(input xlen_t old_val, input xlen_t new_val, input xlen_t w);
      keep_ro = (old_val & ~w) | (new_val & w);
   endfunction

   // Event table where bits 1..10 follow the class order load..div
   function automatic event_vec_t expected_events(input retire_events_t ev);
      event_vec_t v;
      v = '0;
      for (int c = 1; c <= 10; c++)
         v[c[3:0]] = ev.retire && (int'(ev.iclass) == c);
      v[11] = ev.retire && (ev.iclass == class_branch || ev.iclass == class_jal ||
                            ev.iclass == class_jalr);
      v[12] = ev.exc && (ev.cause == 4'd0 || ev.cause == 4'd4 || ev.cause == 4'd6);
      v[13] = ev.exc && (ev.cause == 4'd2);
      v[14] = ev.retire;
      v[15] = ev.ext_irq;
      return v;
   endfunction

   function automatic void model_reset();
      m_mstatus  = '0;
      m_mie      = '0;
      m_mtvec    = `MTVEC_INIT;
      m_mscratch = '0;
      m_mepc     = '0;
      m_mcause   = '0;
      m_mtval    = '0;
      m_mip      = '0;
      m_minhibit = '0;
      for (int i = 0; i < 6; i++)
         m_cnt[i] = '0;
      for (int k = 0; k < 4; k++)
         m_sel[k] = '0;
   endfunction

   function automatic void predict_read(input csr_addr_t a, output xlen_t d, output logic ill);
      d   = '0;
      ill = 1'b0;
      case (a)
         csr_mstatus:       d = m_mstatus;
         csr_misa:          d = `MISA_VALUE;
         csr_mie:           d = m_mie;
         csr_mtvec:         d = m_mtvec;
         csr_mcountinhibit: d = m_minhibit;
         csr_mscratch:      d = m_mscratch;
         csr_mepc:          d = m_mepc;
         csr_mcause:        d = m_mcause;
         csr_mtval:         d = m_mtval;
         csr_mip:           d = m_mip;
         default:           ill = 1'b1;
      endcase
      for (int i = 0; i < 6; i++)
      begin
         if (a == cnt_lo_addr[i] || a == cnt_lo_addr[i] + 12'h080)
         begin
            d   = (a == cnt_lo_addr[i]) ? m_cnt[i][31:0] : m_cnt[i][63:32];
            ill = 1'b0;
         end
      end
      for (int k = 0; k < 4; k++)
      begin
         if (a == sel_addr[k])
         begin
            d   = {28'h0, m_sel[k]};
            ill = 1'b0;
         end
      end
   endfunction

   // One clock edge whose counts use the inhibit bits held before any write
   function automatic void apply_cycle(input logic valid, input csr_req_t rq,
                                       input retire_events_t ev);
      event_vec_t v;
      logic [5:0] inc;
      logic       wr;
      wr     = valid && rq.we;
      v      = expected_events(ev);
      inc[0] = !m_minhibit[0];
      inc[1] = ev.retire && !m_minhibit[2];
      for (int k = 0; k < 4; k++)
         inc[k+2] = v[m_sel[k]] && !m_minhibit[k+3];
      for (int i = 0; i < 6; i++)
      begin
         if (wr && rq.addr == cnt_lo_addr[i])
            m_cnt[i][31:0] = rq.wdata;
         else if (wr && rq.addr == cnt_lo_addr[i] + 12'h080)
            m_cnt[i][63:32] = rq.wdata;
         else if (inc[i])
            m_cnt[i] = m_cnt[i] + 64'd1;
      end
      for (int k = 0; k < 4; k++)
         if (wr && rq.addr == sel_addr[k])
            m_sel[k] = rq.wdata[3:0];
      if (wr)
      begin
         case (rq.addr)
            csr_mstatus:       m_mstatus  = keep_ro(m_mstatus, rq.wdata, wmask_mstatus);
            csr_mie:           m_mie      = keep_ro(m_mie, rq.wdata, wmask_mie);
            csr_mtvec:         m_mtvec    = keep_ro(m_mtvec, rq.wdata, wmask_mtvec);
            csr_mcountinhibit: m_minhibit = keep_ro(m_minhibit, rq.wdata, wmask_minhibit);
            csr_mscratch:      m_mscratch = rq.wdata;
            csr_mepc:          m_mepc     = keep_ro(m_mepc, rq.wdata, wmask_mepc);
            csr_mcause:        m_mcause   = rq.wdata;
            csr_mtval:         m_mtval    = rq.wdata;
            csr_mip:           m_mip      = keep_ro(m_mip, rq.wdata, wmask_mip);
            default:           ;
         endcase
      end
   endfunction

   // --------------------------------------------------
   // Stimulus
   // --------------------------------------------------
   function automatic retire_events_t random_events();
      logic [31:0]    r;
      retire_events_t ev;
      r          = $random(seed);
      ev.retire  = r[0];
      ev.iclass  = instr_class_e'(r[4:1] % 4'd11);
      ev.exc     = r[5] & r[6];
      // Causes 0..7 so that 0, 2, 4 and 6 come up often
      ev.cause   = {1'b0, r[9:7]};
      ev.ext_irq = r[11];
      return ev;
   endfunction

   // Kind 0 trap bank, 1 unimplemented, 2 mcycle/minstret, 3 hpm, 4 inhibit mix
   function automatic csr_req_t random_request(input int kind);
      logic [31:0] r;
      logic [31:0] d;
      logic [31:0] a;
      xlen_t       rd;
      logic        ill;
      csr_req_t    rq;
      r        = $random(seed);
      d        = $random(seed);
      rq.we    = r[0] | r[1];
      rq.addr  = trap_pool[r[11:8] % 4'd10];
      case (kind)
         1:
         begin
            do
            begin
               a       = $random(seed);
               rq.addr = a[11:0];
               predict_read(rq.addr, rd, ill);
            end
            while (!ill);
         end
         2: rq.addr = base_pool[r[9:8]];
         3: rq.addr = hpm_pool[r[11:8] % 4'd12];
         4:
         begin
            rq.addr = r[12] ? base_pool[r[9:8]] : hpm_pool[r[11:8] % 4'd12];
            rq.we   = r[1] & r[2] & r[13];
            if (r[15:14] == 2'b00)
            begin
               rq.addr = csr_mcountinhibit;
               rq.we   = 1'b1;
            end
         end
         default: ;
      endcase
      // Near the top of a half to exercise the carry
      if (r[7:4] == 4'h0)
         d = 32'hFFFF_FFF0 | {28'h0, d[3:0]};
      rq.wdata = d;
      return rq;
   endfunction

   // Called at a falling edge to check the last response and predict this one
   task automatic drive_cycle(input logic valid, input csr_req_t rq, input retire_events_t ev);
      xlen_t d;
      logic  ill;
      nxt_valid  = valid;
      nxt_req    = rq;
      nxt_events = ev;
      @(negedge clk);
      assert (DUT.u_assert.fail_count == 0)
         else fail_run("A bound protocol or mask assertion on the DUT failed");
      assert (rsp_valid == exp_valid)
         else value_error("rsp_valid", 32'(exp_valid), 32'(rsp_valid));
      if (exp_valid)
      begin
         assert (rsp.rdata == exp_rdata)
            else value_error("rsp.rdata", exp_rdata, rsp.rdata);
         assert (rsp.illegal == exp_illegal)
            else value_error("rsp.illegal", 32'(exp_illegal), 32'(rsp.illegal));
      end
      predict_read(rq.addr, d, ill);
      exp_valid   = valid;
      exp_rdata   = d;
      exp_illegal = ill;
      apply_cycle(valid, rq, ev);
   endtask

   task automatic access(input logic we, input csr_addr_t addr, input xlen_t wdata);
      csr_req_t rq;
      rq.we    = we;
      rq.addr  = addr;
      rq.wdata = wdata;
      drive_cycle(1'b1, rq, random_events());
   endtask

   task automatic read_all_trap();
      for (int i = 0; i < 10; i++)
         access(1'b0, trap_pool[i], '0);
   endtask

   task automatic run_random(input int n, input int kind);
      for (int i = 0; i < n; i++)
         drive_cycle(1'b1, random_request(kind), random_events());
   endtask

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------
   initial
   begin
      model_reset();
      repeat (5) @(negedge clk);
      nxt_rst_n = 1'b1;
      // Idle cycle right after release still counts mcycle
      @(negedge clk);
      apply_cycle(1'b0, '0, '0);
      // Reset values, misa and no illegal flags
      read_all_trap();
      // Masked writes to the trap bank
      run_random(n_trap, 0);
      read_all_trap();
      // Unclaimed addresses change nothing
      run_random(n_unimpl, 1);
      read_all_trap();
      // Every counter runs during the counter phases
      access(1'b1, csr_mcountinhibit, 32'h0);
      // Low halves just below the wrap so both counters carry into the high half
      access(1'b1, csr_mcycle, 32'hFFFF_FFFE);
      access(1'b1, csr_minstret, 32'hFFFF_FFFF);
      for (int i = 0; i < n_carry; i++)
         access(1'b0, base_pool[i % 4], '0);
      // Cycle and instret counters with half writes and carries
      run_random(n_base, 2);
      // hpm counters with random selectors
      run_random(n_hpm, 3);
      // Freeze all counters, then let them run again
      access(1'b1, csr_mcountinhibit, 32'hFFFF_FFFF);
      for (int i = 0; i < n_freeze; i++)
         access(1'b0, hpm_pool[i % 8], '0);
      access(1'b1, csr_mcountinhibit, 32'h0);
      for (int i = 0; i < n_freeze; i++)
         access(1'b0, base_pool[i % 4], '0);
      run_random(n_inhibit, 4);
      // Collect the last response
      drive_cycle(1'b0, '0, '0);
      $display("RESULT: PASS");
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+verilog
verilog/csr_map_pkg.sv
verilog/csr_types_pkg.sv
verilog/csr_trap_regs.sv
verilog/csr_event_decode.sv
verilog/csr_counters.sv
verilog/csr_access.sv
verilog/csr_top.sv
tb/csr_assert.sv
tb/csr_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CSR block simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module csr_tb -o csr_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/csr_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "RESULT: PASS"; then
   exit 0
fi
exit 1
